//--- src.f
src/mcuPkg.sv
src/memoryController.sv
src/mcuSequencer.sv
src/bootLoader.sv
src/checksumCore.sv
src/debugPort.sv
src/mappedRegs.sv
src/mcuTop.sv
sim/tbMcuTop.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a failed check exits non-zero.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tbMcuTop -f src.f -o simMcuTop
./obj_dir/simMcuTop

//--- sim/tbMcuTop.sv
//----------------------------------------------------------------------
// Testbench for mcuTop with ROM and SRAM models, an APB driver,
// a reference checksum, compare tasks and bus monitors.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module tbMcuTop import mcuPkg::*; ();

    localparam int BOOT_WORDS  = 16;
    localparam int IDX_W       = $clog2(BOOT_WORDS);
    localparam int SRAM_WORDS  = int'(MAP_BASE);
    localparam int APB_WAIT    = 20;
    localparam int STATE_POLLS = 40;

    // Debug port register offsets.
    localparam logic [7:0] CTRL_REG    = 8'h00;
    localparam logic [7:0] STATUS_REG  = 8'h04;
    localparam logic [7:0] MEMADDR_REG = 8'h08;
    localparam logic [7:0] MEMDATA_REG = 8'h0C;
    localparam logic [7:0] BAD_REG     = 8'h10;

    logic       i_clk = 1'b0;
    logic       i_arstN;
    logic       i_psel;
    logic       i_penable;
    logic       i_pwrite;
    logic [7:0] i_paddr;
    dataT       i_pwdata;
    dataT       o_prdata;
    logic       o_pready;
    logic       o_pslverr;
    addrT       o_romAddr;
    dataT       i_romData;
    addrT       o_memAddr;
    dataT       o_memWData;
    logic       o_memWr;
    logic       o_memExtEn;
    logic       o_memDrive;
    dataT       i_memRData;

    dataT rom   [0:BOOT_WORDS-1];
    dataT image [0:BOOT_WORDS-1];
    dataT sram  [0:SRAM_WORDS-1];

    mcuTop #(.BOOT_WORDS(BOOT_WORDS)) i_mcuTop (
        .i_clk(i_clk), .i_arstN(i_arstN),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_romAddr(o_romAddr), .i_romData(i_romData),
        .o_memAddr(o_memAddr), .o_memWData(o_memWData), .o_memWr(o_memWr),
        .o_memExtEn(o_memExtEn), .o_memDrive(o_memDrive), .i_memRData(i_memRData)
    );

    always #5 i_clk = ~i_clk;

    //------------------------------------------------------------------
    // Memory models.
    //------------------------------------------------------------------
    // ROM and SRAM both answer in the same cycle.
    assign i_romData  = (o_romAddr < addrT'(BOOT_WORDS)) ? rom[o_romAddr[IDX_W-1:0]] : '0;
    assign i_memRData = (o_memAddr < MAP_BASE) ? sram[o_memAddr] : '0;

    // SRAM takes a write only on a driven, enabled write cycle.
    always @(posedge i_clk) begin
        if (o_memDrive && o_memExtEn && o_memWr) begin
            sram[o_memAddr] <= o_memWData;
        end
    end

    //------------------------------------------------------------------
    // Reference model and compare tasks.
    //------------------------------------------------------------------
    // Image checksum, wrapping at 16 bits.
    function automatic dataT refSum(input dataT words [0:BOOT_WORDS-1]);
        dataT acc;
        acc = '0;
        for (int k = 0; k < BOOT_WORDS; k++) begin
            acc = acc + words[k[IDX_W-1:0]];
        end
        return acc;
    endfunction

    task automatic stopRun();
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkData(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkState(input string name, input mcuStateT got, input mcuStateT exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %s (%0d), expected %s (%0d)", $time, name,
                     got.name(), got, exp.name(), exp);
            stopRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %b, expected %b", $time, name, got, exp);
            stopRun();
        end
    endtask

    //------------------------------------------------------------------
    // APB driver.
    //------------------------------------------------------------------
    // Setup phase, then access phase until PREADY; outputs sampled at negedge.
    task automatic apbTransfer(input logic isWrite, input logic [7:0] addr,
                               input dataT wdata, output dataT rdata, output logic err);
        int waitCnt;
        @(posedge i_clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= isWrite;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge i_clk);
        i_penable <= 1'b1;
        waitCnt = 0;
        @(negedge i_clk);
        while (!o_pready) begin
            if (waitCnt == APB_WAIT) begin
                $display("Timeout: no PREADY for APB access at offset %h", addr);
                stopRun();
            end
            waitCnt++;
            @(negedge i_clk);
        end
        rdata = o_prdata;
        err   = o_pslverr;
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input dataT wdata, input logic expErr);
        dataT rd;
        logic err;
        apbTransfer(1'b1, addr, wdata, rd, err);
        checkFlag("o_pslverr", err, expErr);
    endtask

    task automatic apbRead(input logic [7:0] addr, input logic expErr, output dataT rd);
        logic err;
        apbTransfer(1'b0, addr, '0, rd, err);
        checkFlag("o_pslverr", err, expErr);
    endtask

    // Memory read through the MEMADDR and MEMDATA pair.
    task automatic debugRead(input addrT addr, output dataT rd);
        apbWrite(MEMADDR_REG, addr, 1'b0);
        apbRead(MEMDATA_REG, 1'b0, rd);
    endtask

    // Polls STATUS until the wanted state shows up.
    task automatic waitState(input mcuStateT want);
        dataT rd;
        int   polls;
        polls = 0;
        apbRead(STATUS_REG, 1'b0, rd);
        while (mcuStateT'(rd[1:0]) != want) begin
            if (polls == STATE_POLLS) begin
                $display("Timeout: STATUS never reached state %s", want.name());
                stopRun();
            end
            polls++;
            apbRead(STATUS_REG, 1'b0, rd);
        end
    endtask

    //------------------------------------------------------------------
    // Bus monitors.
    //------------------------------------------------------------------
    always @(negedge i_clk) begin
        // Strobes stay off while the bus is not driven or in reset.
        if (!i_arstN || !o_memDrive) begin
            checkFlag("o_memWr", o_memWr, 1'b0);
            checkFlag("o_memExtEn", o_memExtEn, 1'b0);
        end
        if (!i_arstN) begin
            checkFlag("o_pready", o_pready, 1'b0);
            checkFlag("o_pslverr", o_pslverr, 1'b0);
        end
        if (o_memAddr >= MAP_BASE) begin
            if (o_memDrive && o_memExtEn && o_memWr) begin
                $display("SRAM write seen at mapped address %h", o_memAddr);
                stopRun();
            end
            checkFlag("o_memExtEn", o_memExtEn, 1'b0);
        end
    end

    //------------------------------------------------------------------
    // Stimulus.
    //------------------------------------------------------------------
    initial begin
        dataT rd;
        dataT passBefore;
        i_arstN   <= 1'b0;
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        i_paddr   <= '0;
        i_pwdata  <= '0;
        void'($urandom(29));
        for (int k = 0; k < BOOT_WORDS; k++) begin
            rom[k[IDX_W-1:0]]   = dataT'($urandom);
            image[k[IDX_W-1:0]] = rom[k[IDX_W-1:0]];
        end
        repeat (8) @(posedge i_clk);
        i_arstN <= 1'b1;

        // Boot copy is still running right after reset.
        apbRead(STATUS_REG, 1'b0, rd);
        checkState("STATUS", mcuStateT'(rd[1:0]), BOOT);
        apbRead(BAD_REG, 1'b1, rd);
        waitState(RUN);
        // Several passes complete in this time.
        repeat (100) @(posedge i_clk);
        apbWrite(CTRL_REG, 16'h0001, 1'b0);
        waitState(PAUSE);
        apbRead(CTRL_REG, 1'b0, rd);
        checkData("CTRL", rd, 16'h0001);

        for (int k = 0; k < BOOT_WORDS; k++) begin
            debugRead(addrT'(k), rd);
            checkData($sformatf("SRAM word %0d", k), rd, rom[k[IDX_W-1:0]]);
        end
        debugRead(CHECKSUM_ADDR, rd);
        checkData("checksum", rd, refSum(image));
        debugRead(PASSCNT_ADDR, passBefore);
        checkFlag("pass count nonzero", passBefore != '0, 1'b1);

        // Patch two words while paused.
        image[3] = dataT'($urandom);
        image[7] = dataT'($urandom);
        apbWrite(MEMADDR_REG, 16'd3, 1'b0);
        apbWrite(MEMDATA_REG, image[3], 1'b0);
        apbWrite(MEMADDR_REG, 16'd7, 1'b0);
        apbWrite(MEMDATA_REG, image[7], 1'b0);
        debugRead(16'd3, rd);
        checkData("SRAM word 3", rd, image[3]);

        // One partial pass plus two full ones.
        apbWrite(CTRL_REG, 16'h0000, 1'b0);
        waitState(RUN);
        repeat (60) @(posedge i_clk);
        apbWrite(CTRL_REG, 16'h0001, 1'b0);
        waitState(PAUSE);
        debugRead(CHECKSUM_ADDR, rd);
        checkData("checksum", rd, refSum(image));
        debugRead(PASSCNT_ADDR, rd);
        checkFlag("pass count advanced", rd != passBefore, 1'b1);

        // Memory access is refused while running.
        apbWrite(CTRL_REG, 16'h0000, 1'b0);
        waitState(RUN);
        apbWrite(MEMADDR_REG, 16'd5, 1'b0);
        apbWrite(MEMDATA_REG, ~image[5], 1'b1);
        // A write taken on the last edge lands in the model after it.
        @(negedge i_clk);
        for (int k = 0; k < BOOT_WORDS; k++) begin
            checkData($sformatf("SRAM model word %0d", k), sram[addrT'(k)],
                      image[k[IDX_W-1:0]]);
        end
        apbRead(STATUS_REG, 1'b0, rd);
        checkState("STATUS", mcuStateT'(rd[1:0]), RUN);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- src/mcuTop.sv
//----------------------------------------------------------------------
// Memory subsystem top level with APB debug, ROM and SRAM ports.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module mcuTop import mcuPkg::*; #(
    parameter int BOOT_WORDS = 16
) (
    input  logic       i_clk,
    input  logic       i_arstN,
    // APB debug port.
    input  logic       i_psel,
    input  logic       i_penable,
    input  logic       i_pwrite,
    input  logic [7:0] i_paddr,
    input  dataT       i_pwdata,
    output dataT       o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,
    // Boot ROM.
    output addrT       o_romAddr,
    input  dataT       i_romData,
    // External SRAM.
    output addrT       o_memAddr,
    output dataT       o_memWData,
    output logic       o_memWr,
    output logic       o_memExtEn,
    output logic       o_memDrive,
    input  dataT       i_memRData
);

    mcuStateT state;
    logic     isBooted;
    logic     isPaused;
    logic     disableDrive;
    logic     bootDone;
    logic     pauseReq;
    logic     coreRun;
    logic     memMapEn;
    dataT     rdData;
    addrT     bootAddr;
    dataT     bootData;
    logic     bootEn;
    addrT     coreAddr;
    dataT     coreData;
    logic     coreEn;
    logic     coreWr;
    addrT     dbgAddr;
    dataT     dbgData;
    logic     dbgEn;
    logic     dbgWr;

    // Core steps only on a driven bus in RUN.
    assign coreRun = (state == RUN) & o_memDrive;

    //------------------------------------------------------------------
    // Decode stage.
    //------------------------------------------------------------------
    debugPort i_debugPort (
        .i_clk(i_clk), .i_arstN(i_arstN),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .i_state(state), .o_pauseReq(pauseReq), .i_rdData(rdData),
        .o_memAddr(dbgAddr), .o_memData(dbgData), .o_memEn(dbgEn), .o_memWr(dbgWr)
    );

    //------------------------------------------------------------------
    // Execute stage.
    //------------------------------------------------------------------
    mcuSequencer i_sequencer (
        .i_clk(i_clk), .i_arstN(i_arstN),
        .i_bootDone(bootDone), .i_pauseReq(pauseReq),
        .o_state(state), .o_isBooted(isBooted), .o_isPaused(isPaused),
        .o_disableDrive(disableDrive)
    );

    bootLoader #(.BOOT_WORDS(BOOT_WORDS)) i_bootLoader (
        .i_clk(i_clk), .i_arstN(i_arstN), .i_romData(i_romData),
        .o_romAddr(o_romAddr), .o_addr(bootAddr), .o_data(bootData),
        .o_en(bootEn), .o_done(bootDone)
    );

    checksumCore #(.BOOT_WORDS(BOOT_WORDS)) i_core (
        .i_clk(i_clk), .i_arstN(i_arstN), .i_run(coreRun), .i_rdData(rdData),
        .o_addr(coreAddr), .o_data(coreData), .o_en(coreEn), .o_wr(coreWr)
    );

    memoryController i_memCtrl (
        .i_bootAddr(bootAddr), .i_bootData(bootData), .i_bootEn(bootEn),
        .i_coreAddr(coreAddr), .i_coreData(coreData), .i_coreEn(coreEn),
        .i_coreWr(coreWr),
        .i_dbgAddr(dbgAddr), .i_dbgData(dbgData), .i_dbgEn(dbgEn), .i_dbgWr(dbgWr),
        .i_isBooted(isBooted), .i_isPaused(isPaused), .i_disableDrive(disableDrive),
        .o_memAddr(o_memAddr), .o_memWData(o_memWData), .o_memWr(o_memWr),
        .o_memExtEn(o_memExtEn), .o_memMapEn(memMapEn), .o_memDrive(o_memDrive)
    );

    //------------------------------------------------------------------
    // Result stage.
    //------------------------------------------------------------------
    mappedRegs i_mappedRegs (
        .i_clk(i_clk), .i_arstN(i_arstN),
        .i_addr(o_memAddr), .i_wData(o_memWData), .i_wr(o_memWr),
        .i_mapEn(memMapEn), .i_memRData(i_memRData), .o_rdData(rdData)
    );

endmodule

//--- src/mappedRegs.sv
//----------------------------------------------------------------------
// Checksum and pass-count registers with the read-data return mux.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module mappedRegs import mcuPkg::*; (
    input  logic i_clk,
    input  logic i_arstN,
    input  addrT i_addr,
    input  dataT i_wData,
    input  logic i_wr,
    input  logic i_mapEn,
    input  dataT i_memRData,
    output dataT o_rdData
);

    dataT checksum;
    dataT passCnt;

    // Writes to unassigned mapped addresses fall through.
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            checksum <= '0;
            passCnt  <= '0;
        end else if (i_mapEn & i_wr) begin
            if (i_addr == CHECKSUM_ADDR) begin
                checksum <= i_wData;
            end
            if (i_addr == PASSCNT_ADDR) begin
                passCnt <= i_wData;
            end
        end
    end

    // SRAM data unless the access is in mapped space.
    always_comb begin
        o_rdData = i_memRData;
        if (i_mapEn) begin
            case (i_addr)
                CHECKSUM_ADDR: o_rdData = checksum;
                PASSCNT_ADDR:  o_rdData = passCnt;
                default:       o_rdData = '0;
            endcase
        end
    end

endmodule

//--- src/debugPort.sv
//----------------------------------------------------------------------
// APB debug port with pause control and paused memory access.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module debugPort import mcuPkg::*; (
    input  logic       i_clk,
    input  logic       i_arstN,
    // APB slave.
    input  logic       i_psel,
    input  logic       i_penable,
    input  logic       i_pwrite,
    input  logic [7:0] i_paddr,
    input  dataT       i_pwdata,
    output dataT       o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,
    // Sequencer side.
    input  mcuStateT   i_state,
    output logic       o_pauseReq,
    // Memory bus request.
    input  dataT       i_rdData,
    output addrT       o_memAddr,
    output dataT       o_memData,
    output logic       o_memEn,
    output logic       o_memWr
);

    // Register offsets.
    localparam logic [7:0] CTRL_OFF    = 8'h00;
    localparam logic [7:0] STATUS_OFF  = 8'h04;
    localparam logic [7:0] MEMADDR_OFF = 8'h08;
    localparam logic [7:0] MEMDATA_OFF = 8'h0C;

    logic access;
    logic isCtrl;
    logic isStatus;
    logic isMemAddr;
    logic isMemData;
    logic badAddr;
    logic paused;
    logic memStart;
    logic memPhase;
    logic pauseReq;
    addrT memAddr;
    dataT rdCap;

    //------------------------------------------------------------------
    // Transfer decode.
    //------------------------------------------------------------------
    assign access    = i_psel & i_penable;
    assign isCtrl    = (i_paddr == CTRL_OFF);
    assign isStatus  = (i_paddr == STATUS_OFF);
    assign isMemAddr = (i_paddr == MEMADDR_OFF);
    assign isMemData = (i_paddr == MEMDATA_OFF);
    assign badAddr   = ~(isCtrl | isStatus | isMemAddr | isMemData);
    assign paused    = (i_state == PAUSE);

    // Bus cycle runs in the first access cycle of a paused MEMDATA.
    assign memStart  = access & isMemData & paused & ~memPhase;

    // Paused MEMDATA waits one cycle, everything else completes at once.
    assign o_pready  = access & (~(isMemData & paused) | memPhase);
    // Memory is off limits unless paused.
    assign o_pslverr = access & (badAddr | (isMemData & ~paused));

    always_comb begin
        case (i_paddr)
            CTRL_OFF:    o_prdata = dataT'(pauseReq);
            STATUS_OFF:  o_prdata = dataT'(i_state);
            MEMADDR_OFF: o_prdata = memAddr;
            MEMDATA_OFF: o_prdata = rdCap;
            default:     o_prdata = '0;
        endcase
    end

    //------------------------------------------------------------------
    // Registers.
    //------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            pauseReq <= 1'b0;
            memAddr  <= '0;
            memPhase <= 1'b0;
        end else begin
            memPhase <= memStart;
            if (access & o_pready & i_pwrite) begin
                if (isCtrl) begin
                    pauseReq <= i_pwdata[0];
                end
                if (isMemAddr) begin
                    memAddr <= i_pwdata;
                end
            end
        end
    end

    // Read data taken at the end of the bus cycle.
    always_ff @(posedge i_clk) begin
        if (memStart) begin
            rdCap <= i_rdData;
        end
    end

    assign o_pauseReq = pauseReq;
    assign o_memAddr  = memAddr;
    assign o_memData  = i_pwdata;
    assign o_memEn    = memStart;
    assign o_memWr    = memStart & i_pwrite;

endmodule

//--- src/checksumCore.sv
//----------------------------------------------------------------------
// Minimal core summing the loaded image and reporting pass results.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module checksumCore import mcuPkg::*; #(
    parameter int BOOT_WORDS = 16
) (
    input  logic i_clk,
    input  logic i_arstN,
    input  logic i_run,
    input  dataT i_rdData,
    output addrT o_addr,
    output dataT o_data,
    output logic o_en,
    output logic o_wr
);

    localparam addrT LAST_WORD = addrT'(BOOT_WORDS - 1);

    // One pass: read all words, write checksum, write pass count.
    typedef enum logic [1:0] {
        READ_WORDS = 2'd0,
        WRITE_SUM  = 2'd1,
        WRITE_CNT  = 2'd2
    } phaseT;

    phaseT phase;
    addrT  wordIdx;
    dataT  sum;
    dataT  passCnt;

    // Nothing moves unless the core owns a driven bus.
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            phase   <= READ_WORDS;
            wordIdx <= '0;
            sum     <= '0;
            passCnt <= '0;
        end else if (i_run) begin
            case (phase)
                READ_WORDS: begin
                    // SRAM answers in the same cycle.
                    sum <= sum + i_rdData;
                    if (wordIdx == LAST_WORD) begin
                        wordIdx <= '0;
                        phase   <= WRITE_SUM;
                    end else begin
                        wordIdx <= wordIdx + addrT'(1);
                    end
                end
                WRITE_SUM: begin
                    passCnt <= passCnt + dataT'(1);
                    phase   <= WRITE_CNT;
                end
                WRITE_CNT: begin
                    // Next pass sums from zero.
                    sum   <= '0;
                    phase <= READ_WORDS;
                end
                default: phase <= READ_WORDS;
            endcase
        end
    end

    always_comb begin
        case (phase)
            WRITE_SUM: o_addr = CHECKSUM_ADDR;
            WRITE_CNT: o_addr = PASSCNT_ADDR;
            default:   o_addr = wordIdx;
        endcase
    end

    // Pass count is already bumped when its write goes out.
    assign o_data = (phase == WRITE_SUM) ? sum : passCnt;
    assign o_en   = i_run;
    assign o_wr   = i_run & (phase != READ_WORDS);

endmodule

//--- src/bootLoader.sv
//----------------------------------------------------------------------
// Boot loader streaming the ROM image into external SRAM.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module bootLoader import mcuPkg::*; #(
    parameter int BOOT_WORDS = 16
) (
    input  logic i_clk,
    input  logic i_arstN,
    input  dataT i_romData,
    output addrT o_romAddr,
    output addrT o_addr,
    output dataT o_data,
    output logic o_en,
    output logic o_done
);

    localparam addrT LAST_WORD = addrT'(BOOT_WORDS - 1);

    addrT wordCnt;
    logic busy;
    logic done;

    // Idle for one cycle after reset, then one word per cycle.
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            wordCnt <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
        end else if (busy) begin
            wordCnt <= wordCnt + addrT'(1);
            if (wordCnt == LAST_WORD) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (!done) begin
            busy <= 1'b1;
        end
    end

    // ROM word k lands at SRAM word k.
    assign o_romAddr = wordCnt;
    assign o_addr    = wordCnt;
    assign o_data    = i_romData;
    assign o_en      = busy;
    // Done stays high until the next reset.
    assign o_done    = done;

endmodule

//--- src/mcuSequencer.sv
//----------------------------------------------------------------------
// Boot, run and pause sequencer with bus turnaround cycles.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module mcuSequencer import mcuPkg::*; (
    input  logic     i_clk,
    input  logic     i_arstN,
    input  logic     i_bootDone,
    input  logic     i_pauseReq,
    output mcuStateT o_state,
    output logic     o_isBooted,
    output logic     o_isPaused,
    output logic     o_disableDrive
);

    mcuStateT state;
    logic     turnaround;

    // Every change of state moves the bus to a new owner.
    // The new owner is selected at once but held off the bus one cycle.
    always_ff @(posedge i_clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state      <= BOOT;
            turnaround <= 1'b0;
        end else begin
            turnaround <= 1'b0;
            // No new change while a turnaround is in progress.
            if (!turnaround) begin
                case (state)
                    BOOT: begin
                        if (i_bootDone) begin
                            state      <= RUN;
                            turnaround <= 1'b1;
                        end
                    end
                    RUN: begin
                        if (i_pauseReq) begin
                            state      <= PAUSE;
                            turnaround <= 1'b1;
                        end
                    end
                    PAUSE: begin
                        if (!i_pauseReq) begin
                            state      <= RUN;
                            turnaround <= 1'b1;
                        end
                    end
                    // Unused encoding restarts the boot.
                    default: state <= BOOT;
                endcase
            end
        end
    end

    assign o_state        = state;
    assign o_isBooted     = (state != BOOT);
    assign o_isPaused     = (state == PAUSE);
    assign o_disableDrive = turnaround;

endmodule

//--- src/memoryController.sv
//----------------------------------------------------------------------
// Bus owner multiplexer with SRAM/mapped decode and drive gating.
//----------------------------------------------------------------------
`timescale 1ns/1ns

module memoryController import mcuPkg::*; (
    // Boot loader requests (writes only).
    input  addrT i_bootAddr,
    input  dataT i_bootData,
    input  logic i_bootEn,
    // Core requests.
    input  addrT i_coreAddr,
    input  dataT i_coreData,
    input  logic i_coreEn,
    input  logic i_coreWr,
    // Debug port requests.
    input  addrT i_dbgAddr,
    input  dataT i_dbgData,
    input  logic i_dbgEn,
    input  logic i_dbgWr,
    // Owner select and drive control from the sequencer.
    input  logic i_isBooted,
    input  logic i_isPaused,
    input  logic i_disableDrive,
    // Selected bus.
    output addrT o_memAddr,
    output dataT o_memWData,
    output logic o_memWr,
    output logic o_memExtEn,
    output logic o_memMapEn,
    output logic o_memDrive
);

    // Packed request is {en, wr, data, addr}.
    localparam int CTRL_W = 2 + $bits(dataT) + $bits(addrT);

    logic [CTRL_W-1:0] bootCtrl;
    logic [CTRL_W-1:0] coreCtrl;
    logic [CTRL_W-1:0] dbgCtrl;
    logic [CTRL_W-1:0] bootedCtrl;
    logic [CTRL_W-1:0] busCtrl;
    addrT              selAddr;
    dataT              selData;
    logic              selWr;
    logic              selEn;
    logic              isMapped;

    //------------------------------------------------------------------
    // Owner selection.
    //------------------------------------------------------------------
    // Boot loader only ever writes.
    assign bootCtrl = {i_bootEn, 1'b1, i_bootData, i_bootAddr};
    assign coreCtrl = {i_coreEn, i_coreWr, i_coreData, i_coreAddr};
    assign dbgCtrl  = {i_dbgEn, i_dbgWr, i_dbgData, i_dbgAddr};

    // First level picks run vs. pause, second level boot vs. booted.
    assign bootedCtrl = i_isPaused ? dbgCtrl : coreCtrl;
    assign busCtrl    = i_isBooted ? bootedCtrl : bootCtrl;

    assign {selEn, selWr, selData, selAddr} = busCtrl;

    //------------------------------------------------------------------
    // Decode and drive gating.
    //------------------------------------------------------------------
    assign isMapped   = (selAddr >= MAP_BASE);

    // Drive enable stands in for the tristate control.
    assign o_memDrive = ~i_disableDrive;

    assign o_memAddr  = selAddr;
    assign o_memWData = selData;
    // Strobes only leave the block while the bus is driven.
    assign o_memWr    = selEn & selWr & o_memDrive;
    assign o_memExtEn = selEn & ~isMapped & o_memDrive;
    assign o_memMapEn = selEn & isMapped & o_memDrive;

endmodule

//--- src/mcuPkg.sv
//----------------------------------------------------------------------
// Bus word types, sequencer state encoding and the address map.
//----------------------------------------------------------------------
package mcuPkg;

    // Memory bus address and data words.
    typedef logic [15:0] addrT;
    typedef logic [15:0] dataT;

    // Sequencer states, one per bus owner.
    typedef enum logic [1:0] {
        BOOT  = 2'd0,
        RUN   = 2'd1,
        PAUSE = 2'd2
    } mcuStateT;

    //------------------------------------------------------------------
    // Address map.
    //------------------------------------------------------------------
    // External SRAM sits below MAP_BASE, mapped registers at and above.
    localparam addrT MAP_BASE      = 16'hC000;
    localparam addrT CHECKSUM_ADDR = 16'hC000;
    localparam addrT PASSCNT_ADDR  = 16'hC001;

endpackage
